//--- filelist.f
rtl/uart_pkg.sv
rtl/uart_baud_gen.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/uart.sv
dv/uart_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module uart_tb \
    -o uart_tb_sim > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/uart_tb_sim > sim.log 2>&1
cat sim.log
grep -qx "RESULT: PASS" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

//--- dv/uart_tb.sv
`timescale 1ns/1ps

module uart_tb;

    import uart_pkg::*;

    localparam int div_n      = 3;
    localparam int bit_clks   = 16 * (div_n + 1);
    localparam int n_fixed    = 7;
    localparam int n_cases    = 11;
    localparam int max_cycles = n_cases * 2 * 12 * bit_clks + 4000; // Overrun cases send two frames

    typedef enum logic [1:0]
    {
        k_tx,
        k_rx,
        k_ovr
    } kind_t;

    typedef struct packed
    {
        kind_t      kind;
        logic [7:0] data;
        logic       odd;
        logic       bad_par;
        logic       bad_stop;
        logic [7:0] ctrl;
    } case_t;

    logic       clk;
    logic       rst;
    logic       cyc;
    logic       stb;
    logic       we;
    logic [1:0] adr;
    logic [7:0] dat_w;
    logic [7:0] dat_r;
    logic       ack;
    logic       rxd;
    logic       txd;
    logic       irq;
    logic       iack;

    case_t       cases [n_cases];
    int          errors;
    int          checks;
    int          cycles = 0;
    logic [31:0] lfsr;

    uart #(
        .div_w(16)
    ) DUT (
        .clk  (clk),
        .rst  (rst),
        .cyc  (cyc),
        .stb  (stb),
        .we   (we),
        .adr  (adr),
        .dat_w(dat_w),
        .dat_r(dat_r),
        .ack  (ack),
        .rxd  (rxd),
        .txd  (txd),
        .irq  (irq),
        .iack (iack)
    );

    always #2 clk = ~clk;

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= max_cycles)
        begin
            $display("Timeout: the run did not finish within %0d cycles", max_cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0])
        begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    task automatic take_bits(input int n, output logic [7:0] v);
        int i;
        v = 8'h00;
        for (i = 0; i < n; i++)
        begin
            v    = {v[6:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    function automatic logic [7:0] stat_word(input logic tbre, rbrf, fe, oe, pe, tc);
        logic [7:0] w;
        w          = 8'h00;
        w[st_tbre] = tbre;
        w[st_rbrf] = rbrf;
        w[st_fe]   = fe;
        w[st_oe]   = oe;
        w[st_pe]   = pe;
        w[st_tc]   = tc;
        return w;
    endfunction

    task automatic check_val(input string name, input logic [7:0] exp, input logic [7:0] got);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("ERROR at %0t: %s expected %02h, got %02h", $time, name, exp, got);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("ERROR at %0t: %s expected %b, got %b", $time, name, exp, got);
        end
    endtask

    task automatic wb_access(input logic wr, input logic [1:0] a, input logic [7:0] wd,
                             output logic [7:0] rd);
        int waited;
        waited = 0;
        @(posedge clk);
        #0.5;
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = wr;
        adr   = a;
        dat_w = wd;
        @(negedge clk);
        while (!ack && waited < 16)
        begin
            @(negedge clk);
            waited++;
        end
        checks++;
        assert (ack)
        else
        begin
            errors++;
            $display("The DUT gave no ack for an access to address %0d", a);
        end
        rd = dat_r; // Valid during the ack clock
        @(posedge clk);
        #0.5;
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
        @(negedge clk);
        check_bit("ack", 1'b0, ack); // One clock only
    endtask

    task automatic wb_write(input logic [1:0] a, input logic [7:0] d);
        logic [7:0] unused;
        wb_access(1'b1, a, d, unused);
    endtask

    task automatic wb_read(input logic [1:0] a, output logic [7:0] d);
        wb_access(1'b0, a, 8'h00, d);
    endtask

    task automatic poll_status(input int bit_pos, output logic [7:0] s);
        int tries;
        tries = 0;
        wb_read(addr_ctrl_stat, s);
        while (!s[bit_pos] && tries < 64)
        begin
            wb_read(addr_ctrl_stat, s);
            tries++;
        end
        checks++;
        assert (s[bit_pos])
        else
        begin
            errors++;
            $display("Status bit %0d never became set", bit_pos);
        end
    endtask

    task automatic pulse_iack(output logic irq_next, output logic irq_later);
        @(posedge clk);
        #0.5;
        iack = 1'b1;
        @(posedge clk);
        #0.5;
        iack = 1'b0;
        @(negedge clk);
        irq_next = irq;
        @(negedge clk);
        irq_later = irq;
    endtask

    task automatic send_frame(input logic [7:0] b, input logic odd, input logic bad_par,
                              input logic bad_stop);
        logic [10:0] frame;
        logic        par;
        int          i;
        par   = (^b) ^ odd ^ bad_par;
        frame = {!bad_stop, par, b, 1'b0};
        for (i = 0; i < 11; i++)
        begin
            @(posedge clk);
            #0.5;
            rxd = frame[i];
            repeat (bit_clks - 1) @(posedge clk);
        end
        @(posedge clk);
        #0.5;
        rxd = 1'b1; // One idle bit between frames
        repeat (bit_clks - 1) @(posedge clk);
    endtask

    task automatic recv_frame(output logic [7:0] b, output logic par, output logic stop);
        int waited;
        int i;
        waited = 0;
        b      = 8'h00;
        @(negedge clk);
        while (txd && waited < 4 * bit_clks)
        begin
            @(negedge clk);
            waited++;
        end
        checks++;
        assert (!txd)
        else
        begin
            errors++;
            $display("No start bit appeared on txd");
        end
        repeat (bit_clks / 2) @(negedge clk); // Middle of the start bit
        check_bit("txd start", 1'b0, txd);
        for (i = 0; i < 8; i++)
        begin
            repeat (bit_clks) @(negedge clk);
            b[i] = txd;
        end
        repeat (bit_clks) @(negedge clk);
        par = txd;
        repeat (bit_clks) @(negedge clk);
        stop = txd;
    endtask

    task automatic run_tx(input case_t c);
        logic [7:0] got_b;
        logic [7:0] s;
        logic       got_par;
        logic       got_stop;
        fork
            recv_frame(got_b, got_par, got_stop);
            begin
                wb_write(addr_data, c.data);
                wb_read(addr_ctrl_stat, s);
                check_bit("status tbre after write", 1'b0, s[st_tbre]);
                poll_status(st_tbre, s);
            end
        join
        check_val("txd data", c.data, got_b);
        check_bit("txd parity", (^c.data) ^ c.odd, got_par);
        check_bit("txd stop", 1'b1, got_stop);
        repeat (bit_clks / 2 + 4) @(posedge clk); // Past the end of the stop bit
        wb_read(addr_ctrl_stat, s);
        check_val("status after frame", stat_word(1, 0, 0, 0, 0, 1), s);
        wb_read(addr_ctrl_stat, s);
        check_val("status second read", stat_word(1, 0, 0, 0, 0, 0), s);
        check_bit("irq after frame", c.ctrl[ctl_tie], irq);
    endtask

    task automatic run_rx(input case_t c);
        logic [7:0] s;
        logic [7:0] d;
        logic       nxt;
        logic       later;
        if (c.kind == k_ovr)
        begin
            send_frame(c.data, c.odd, 1'b0, 1'b0);
            poll_status(st_rbrf, s);
            check_val("status first frame", stat_word(1, 1, 0, 0, 0, 0), s);
            send_frame(~c.data, c.odd, 1'b0, 1'b0);
            poll_status(st_oe, s);
            check_val("status overrun", stat_word(1, 1, 0, 1, 0, 0), s);
        end
        else
        begin
            send_frame(c.data, c.odd, c.bad_par, c.bad_stop);
            poll_status(st_rbrf, s);
            check_val("status after frame", stat_word(1, 1, c.bad_stop, 0, c.bad_par, 0), s);
        end
        wb_read(addr_ctrl_stat, s);
        check_val("status second read", stat_word(1, 1, 0, 0, 0, 0), s);
        check_bit("irq with rbrf", c.ctrl[ctl_rie], irq);
        pulse_iack(nxt, later);
        check_bit("irq during iack", 1'b0, nxt);
        check_bit("irq after iack", c.ctrl[ctl_rie], later);
        wb_read(addr_data, d);
        check_val("rx data", c.data, d); // First byte survives an overrun
        wb_read(addr_ctrl_stat, s);
        check_val("status after data read", stat_word(1, 0, 0, 0, 0, 0), s);
        pulse_iack(nxt, later);
        check_bit("irq after rbrf cleared", 1'b0, later);
    endtask

    task automatic run_case(input case_t c);
        logic nxt;
        logic later;
        wb_write(addr_ctrl_stat, c.ctrl | (8'(c.odd) << ctl_odd));
        pulse_iack(nxt, later);
        check_bit("irq during iack", 1'b0, nxt);
        check_bit("irq after control write", c.ctrl[ctl_tie], later); // TBRE is 1 here
        if (c.kind == k_tx)
        begin
            run_tx(c);
        end
        else
        begin
            run_rx(c);
        end
    endtask

    initial
    begin
        logic [7:0] s;
        logic [7:0] rnd;
        logic [7:0] rb;
        int         i;
        clk    = 1'b0;
        rst    = 1'b1;
        cyc    = 1'b0;
        stb    = 1'b0;
        we     = 1'b0;
        adr    = 2'd0;
        dat_w  = 8'h00;
        rxd    = 1'b1;
        iack   = 1'b0;
        errors = 0;
        checks = 0;
        lfsr   = 32'd70224;

        cases[0] = '{k_tx,  8'h55, 1'b0, 1'b0, 1'b0, 8'h00};
        cases[1] = '{k_tx,  8'hA3, 1'b1, 1'b0, 1'b0, 8'h80}; // TIE
        cases[2] = '{k_rx,  8'h3C, 1'b0, 1'b0, 1'b0, 8'h40}; // RIE
        cases[3] = '{k_rx,  8'h81, 1'b1, 1'b0, 1'b0, 8'h00};
        cases[4] = '{k_rx,  8'h5A, 1'b0, 1'b1, 1'b0, 8'h00};
        cases[5] = '{k_rx,  8'hF0, 1'b1, 1'b0, 1'b1, 8'h40};
        cases[6] = '{k_ovr, 8'h12, 1'b0, 1'b0, 1'b0, 8'h00};
        for (i = n_fixed; i < n_cases; i++)
        begin
            take_bits(8, rnd);
            take_bits(1, rb);
            cases[i].kind     = (i % 2 == 0) ? k_tx : k_rx;
            cases[i].data     = rnd;
            cases[i].odd      = rb[0];
            cases[i].bad_par  = 1'b0;
            cases[i].bad_stop = 1'b0;
            take_bits(1, rb);
            cases[i].ctrl     = 8'h00;
            if (rb[0])
            begin
                cases[i].ctrl = (cases[i].kind == k_tx) ? 8'h80 : 8'h40;
            end
        end

        repeat (16) @(posedge clk);
        #0.5;
        rst = 1'b0;
        @(negedge clk);
        check_bit("irq after reset", 1'b0, irq);
        check_bit("ack after reset", 1'b0, ack);
        wb_read(addr_ctrl_stat, s);
        check_val("status after reset", 8'h80, s);

        wb_write(addr_scale_lo, 8'(div_n));
        wb_write(addr_scale_hi, 8'h00);
        wb_read(addr_scale_lo, s);
        check_val("read of address 2", 8'h00, s);
        wb_read(addr_scale_hi, s);
        check_val("read of address 3", 8'h00, s);

        for (i = 0; i < n_cases; i++)
        begin
            run_case(cases[i]);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
        begin
            $display("RESULT: PASS");
        end
        else
        begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- rtl/uart.sv
`timescale 1ns/1ps

module uart #(
    parameter int div_w = 16
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       cyc,
    input  logic       stb,
    input  logic       we,
    input  logic [1:0] adr,
    input  logic [7:0] dat_w,
    output logic [7:0] dat_r,
    output logic       ack,
    input  logic       rxd,
    output logic       txd,
    output logic       irq,
    input  logic       iack
);

    import uart_pkg::*;

    logic       req;
    logic       ld_ctrl;
    logic       ld_data;
    logic       ld_scale_lo;
    logic       ld_scale_hi;
    logic       rd_stat;
    logic       rd_data;
    logic [7:0] ctrl;
    logic [7:0] stat;
    logic [7:0] rbr;
    logic       tbre, rbrf, fe, oe, pe, tc;
    logic       rx_tick, tx_tick;
    logic       set_tbre, set_tc, set_rbrf, set_fe, set_pe, set_oe;
    logic       parity_odd;
    logic       int_cond;

    assign req = cyc && stb && !ack;

    // Register strobes fire during the ack clock
    always_comb
    begin
        ld_ctrl     = 1'b0;
        ld_data     = 1'b0;
        ld_scale_lo = 1'b0;
        ld_scale_hi = 1'b0;
        rd_stat     = 1'b0;
        rd_data     = 1'b0;
        if (ack)
        begin
            case (adr)
                addr_ctrl_stat:
                begin
                    ld_ctrl = we;
                    rd_stat = !we;
                end
                addr_data:
                begin
                    ld_data = we;
                    rd_data = !we;
                end
                addr_scale_lo: ld_scale_lo = we;
                addr_scale_hi: ld_scale_hi = we;
                default: ;
            endcase
        end
    end

    always_comb
    begin
        stat          = 8'h00;
        stat[st_tbre] = tbre;
        stat[st_rbrf] = rbrf;
        stat[st_fe]   = fe;
        stat[st_oe]   = oe;
        stat[st_pe]   = pe;
        stat[st_tc]   = tc;
    end

    assign parity_odd = ctrl[ctl_odd];
    assign int_cond   = (ctrl[ctl_tie] && tbre) || (ctrl[ctl_rie] && rbrf);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            ack   <= 1'b0;
            dat_r <= 8'h00;
            ctrl  <= 8'h00;
        end
        else
        begin
            ack <= req;
            if (req && !we)
            begin
                case (adr)
                    addr_ctrl_stat: dat_r <= stat;
                    addr_data:      dat_r <= rbr;
                    default:        dat_r <= 8'h00; // Divisor is write only
                endcase
            end
            if (ld_ctrl)
            begin
                ctrl <= dat_w;
            end
        end
    end

    // Sticky flags, a set pulse beats a clear in the same clock
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            tbre <= 1'b1;
            rbrf <= 1'b0;
            fe   <= 1'b0;
            oe   <= 1'b0;
            pe   <= 1'b0;
            tc   <= 1'b0;
        end
        else
        begin
            tbre <= set_tbre || (tbre && !ld_data);
            rbrf <= set_rbrf || (rbrf && !rd_data);
            fe   <= set_fe || (fe && !rd_stat);
            oe   <= set_oe || (oe && !rd_stat);
            pe   <= set_pe || (pe && !rd_stat);
            tc   <= set_tc || (tc && !rd_stat);
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            irq <= 1'b0;
        end
        else if (iack && irq)
        begin
            irq <= 1'b0;
        end
        else if (int_cond)
        begin
            irq <= 1'b1;
        end
    end

    uart_baud_gen #(
        .div_w(div_w)
    ) u_baud (
        .clk        (clk),
        .rst        (rst),
        .scale_lo_ld(ld_scale_lo),
        .scale_hi_ld(ld_scale_hi),
        .scale_val  (dat_w),
        .rx_tick    (rx_tick),
        .tx_tick    (tx_tick)
    );

    uart_rx u_rx (
        .clk     (clk),
        .rst     (rst),
        .rx_tick (rx_tick),
        .rxd     (rxd),
        .odd     (parity_odd),
        .rbrf    (rbrf),
        .rbr     (rbr),
        .set_rbrf(set_rbrf),
        .set_fe  (set_fe),
        .set_pe  (set_pe),
        .set_oe  (set_oe)
    );

    uart_tx u_tx (
        .clk     (clk),
        .rst     (rst),
        .tx_tick (tx_tick),
        .load    (ld_data),
        .din     (dat_w),
        .odd     (parity_odd),
        .txd     (txd),
        .set_tbre(set_tbre),
        .set_tc  (set_tc)
    );

endmodule

//--- rtl/uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
    input  logic       clk,
    input  logic       rst,
    input  logic       tx_tick,
    input  logic       load,
    input  logic [7:0] din,
    input  logic       odd,
    output logic       txd,
    output logic       set_tbre,
    output logic       set_tc
);

    import uart_pkg::*;

    tx_state_t  state;
    logic [7:0] hold;
    logic       hold_full;
    logic [7:0] shift;
    logic       par_bit;
    logic [2:0] bit_cnt;
    logic       xfer;

    // Holding register moves to the shifter at a bit boundary
    assign xfer = tx_tick && hold_full && (state == tx_idle || state == tx_stop);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            hold      <= 8'h00;
            hold_full <= 1'b0;
        end
        else if (load)
        begin
            hold      <= din; // Overwrites a pending byte
            hold_full <= 1'b1;
        end
        else if (xfer)
        begin
            hold_full <= 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state    <= tx_idle;
            shift    <= 8'h00;
            par_bit  <= 1'b0;
            bit_cnt  <= 3'd0;
            txd      <= 1'b1;
            set_tbre <= 1'b0;
            set_tc   <= 1'b0;
        end
        else
        begin
            set_tbre <= 1'b0;
            set_tc   <= 1'b0;
            if (xfer)
            begin
                shift    <= hold;
                par_bit  <= (^hold) ^ odd;
                txd      <= 1'b0; // Start bit
                state    <= tx_start;
                set_tbre <= !load; // A new byte just landed in hold
            end
            else if (tx_tick)
            begin
                case (state)
                    tx_idle: txd <= 1'b1;
                    tx_start:
                    begin
                        txd     <= shift[0];
                        shift   <= shift >> 1;
                        bit_cnt <= 3'd0;
                        state   <= tx_data;
                    end
                    tx_data:
                    begin
                        if (bit_cnt == 3'd7)
                        begin
                            txd   <= par_bit;
                            state <= tx_parity;
                        end
                        else
                        begin
                            txd     <= shift[0];
                            shift   <= shift >> 1;
                            bit_cnt <= bit_cnt + 3'd1;
                        end
                    end
                    tx_parity:
                    begin
                        txd   <= 1'b1; // Stop bit
                        state <= tx_stop;
                    end
                    tx_stop:
                    begin
                        set_tc <= 1'b1;
                        state  <= tx_idle;
                    end
                    default: state <= tx_idle;
                endcase
            end
        end
    end

endmodule

//--- rtl/uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
    input  logic       clk,
    input  logic       rst,
    input  logic       rx_tick,
    input  logic       rxd,
    input  logic       odd,
    input  logic       rbrf,
    output logic [7:0] rbr,
    output logic       set_rbrf,
    output logic       set_fe,
    output logic       set_pe,
    output logic       set_oe
);

    import uart_pkg::*;

    rx_state_t  state;
    logic       rxd_meta;
    logic       rxd_s;
    logic       rxd_prev;  // Line level at the previous tick
    logic [3:0] tick_cnt;
    logic [2:0] bit_cnt;
    logic [7:0] shift;
    logic       par_acc;
    logic       par_bad;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            rxd_meta <= 1'b1;
            rxd_s    <= 1'b1;
        end
        else
        begin
            rxd_meta <= rxd;
            rxd_s    <= rxd_meta;
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state    <= rx_idle;
            rxd_prev <= 1'b1;
            tick_cnt <= 4'd0;
            bit_cnt  <= 3'd0;
            shift    <= 8'h00;
            rbr      <= 8'h00;
            par_acc  <= 1'b0;
            par_bad  <= 1'b0;
            set_rbrf <= 1'b0;
            set_fe   <= 1'b0;
            set_pe   <= 1'b0;
            set_oe   <= 1'b0;
        end
        else
        begin
            set_rbrf <= 1'b0;
            set_fe   <= 1'b0;
            set_pe   <= 1'b0;
            set_oe   <= 1'b0;
            if (rx_tick)
            begin
                rxd_prev <= rxd_s;
                tick_cnt <= tick_cnt + 4'd1;
                case (state)
                    rx_idle:
                    begin
                        if (rxd_prev && !rxd_s) // Falling edge
                        begin
                            state    <= rx_start;
                            tick_cnt <= 4'd0;
                        end
                    end
                    rx_start:
                    begin
                        if (tick_cnt == 4'd7)
                        begin
                            if (rxd_s)
                            begin
                                state <= rx_idle; // Glitch, not a start bit
                            end
                            else
                            begin
                                state    <= rx_data;
                                tick_cnt <= 4'd0;
                                bit_cnt  <= 3'd0;
                                par_acc  <= 1'b0;
                            end
                        end
                    end
                    rx_data:
                    begin
                        if (tick_cnt == 4'd15)
                        begin
                            shift   <= {rxd_s, shift[7:1]}; // LSB first
                            par_acc <= par_acc ^ rxd_s;
                            bit_cnt <= bit_cnt + 3'd1;
                            if (bit_cnt == 3'd7)
                            begin
                                state <= rx_parity;
                            end
                        end
                    end
                    rx_parity:
                    begin
                        if (tick_cnt == 4'd15)
                        begin
                            par_bad <= ((par_acc ^ rxd_s) != odd);
                            state   <= rx_stop;
                        end
                    end
                    rx_stop:
                    begin
                        if (tick_cnt == 4'd15)
                        begin
                            if (rbrf)
                            begin
                                set_oe <= 1'b1; // Old byte kept
                            end
                            else
                            begin
                                set_rbrf <= 1'b1;
                                rbr      <= shift;
                            end
                            set_fe <= !rxd_s;
                            set_pe <= par_bad;
                            state  <= rx_idle;
                        end
                    end
                    default: state <= rx_idle;
                endcase
            end
        end
    end

endmodule

//--- rtl/uart_baud_gen.sv
`timescale 1ns/1ps

module uart_baud_gen #(
    parameter int div_w = 16
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       scale_lo_ld,
    input  logic       scale_hi_ld,
    input  logic [7:0] scale_val,
    output logic       rx_tick,
    output logic       tx_tick
);

    localparam int hi_w = div_w - 8;

    logic [div_w-1:0] divisor;
    logic [div_w-1:0] count;
    logic [3:0]       sub_count;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            divisor <= '0;
        end
        else
        begin
            if (scale_lo_ld)
            begin
                divisor[7:0] <= scale_val;
            end
            if (scale_hi_ld)
            begin
                divisor[div_w-1:8] <= hi_w'(scale_val);
            end
        end
    end

    // Oversample tick every divisor+1 clocks, bit tick every 16th of those
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            count     <= '0;
            sub_count <= 4'd0;
            rx_tick   <= 1'b0;
            tx_tick   <= 1'b0;
        end
        else if (count == '0)
        begin
            count     <= divisor;
            sub_count <= sub_count + 4'd1;
            rx_tick   <= 1'b1;
            tx_tick   <= (sub_count == 4'hf);
        end
        else
        begin
            count   <= count - 1'b1;
            rx_tick <= 1'b0;
            tx_tick <= 1'b0;
        end
    end

endmodule

//--- rtl/uart_pkg.sv
package uart_pkg;

    // Register map
    localparam logic [1:0] addr_ctrl_stat = 2'd0;
    localparam logic [1:0] addr_data      = 2'd1;
    localparam logic [1:0] addr_scale_lo  = 2'd2;
    localparam logic [1:0] addr_scale_hi  = 2'd3;

    // Status word bit positions, bits 1:0 read as zero
    localparam int st_tbre = 7;
    localparam int st_rbrf = 6;
    localparam int st_fe   = 5;
    localparam int st_oe   = 4;
    localparam int st_pe   = 3;
    localparam int st_tc   = 2;

    localparam int ctl_tie = 7;
    localparam int ctl_rie = 6;
    localparam int ctl_odd = 5; // 0 even, 1 odd

    typedef enum logic [2:0]
    {
        rx_idle,
        rx_start,
        rx_data,
        rx_parity,
        rx_stop
    } rx_state_t;

    typedef enum logic [2:0]
    {
        tx_idle,
        tx_start,
        tx_data,
        tx_parity,
        tx_stop
    } tx_state_t;

endpackage
